// ==== include/core_defs.svh ====
`ifndef CORE_DEFS_SVH
`define CORE_DEFS_SVH

// datapath
`define CORE_XLEN 32
`define CORE_NREG 32
`define CORE_RADDR_W 5
`define CORE_IMM_W 16

// wait window entries
`define CORE_WIN_DEPTH 3

// identical integer lanes
`define CORE_N_LANES 2

// issue to lane result for a multiply
`define CORE_MUL_CYCLES 4

`endif

// ==== logic/isa_pkg.sv ====
`include "core_defs.svh"

package isa_pkg;

	typedef enum logic [3:0] {
		NOP  = 4'd0,
		ADD  = 4'd1,
		SUB  = 4'd2,
		AND  = 4'd3,
		OR   = 4'd4,
		XOR  = 4'd5,
		SLL  = 4'd6,
		SRL  = 4'd7,
		ADDI = 4'd8,
		LUI  = 4'd9,
		MUL  = 4'd10
	} op_e;

	// decoded operation of 35 bits
	typedef struct packed {
		op_e                     op;
		logic [`CORE_RADDR_W-1:0] ds;
		logic [`CORE_RADDR_W-1:0] dt;
		logic [`CORE_RADDR_W-1:0] dd;
		logic [`CORE_IMM_W-1:0]   imm;
	} uop_t;

	function automatic logic uses_ds(input op_e op);
		return !(op == NOP || op == LUI);
	endfunction

	// addi takes its second operand from imm
	function automatic logic uses_dt(input op_e op);
		return !(op == NOP || op == LUI || op == ADDI);
	endfunction

endpackage

// ==== logic/pipe_pkg.sv ====
`include "core_defs.svh"

package pipe_pkg;

	typedef struct packed {
		logic          valid;
		isa_pkg::uop_t uop;
	} win_entry_t;

	// operands already read, so the lane never touches the register file
	typedef struct packed {
		logic                     valid;
		isa_pkg::op_e             op;
		logic [`CORE_RADDR_W-1:0] dd;
		logic [`CORE_XLEN-1:0]    ds_val;
		logic [`CORE_XLEN-1:0]    dt_val;
		logic [`CORE_IMM_W-1:0]   imm;
	} lane_req_t;

	// lane result and writeback element of 38 bits
	typedef struct packed {
		logic                     valid;
		logic [`CORE_RADDR_W-1:0] addr;
		logic [`CORE_XLEN-1:0]    data;
	} wb_t;

endpackage

// ==== logic/issue_window.sv ====
`timescale 1ns/1ps
`include "core_defs.svh"

module issue_window (
	input  logic                       clk,
	input  logic                       rstn,
	input  isa_pkg::uop_t              i_uop [2],
	input  logic [1:0]                 i_vld,
	input  logic [`CORE_WIN_DEPTH-1:0] i_issued,
	output pipe_pkg::win_entry_t       o_entries [`CORE_WIN_DEPTH],
	output logic                       o_busy
);
	import isa_pkg::*;
	import pipe_pkg::*;

	localparam int DEPTH = `CORE_WIN_DEPTH;
	localparam int IDX_W = $clog2(DEPTH);
	localparam int CNT_W = $clog2(DEPTH + 3);

	win_entry_t nxt [DEPTH];
	logic [CNT_W-1:0] fill;
	logic [1:0] acc;

	// nops are taken from the source but never stored
	always_comb begin
		for (int s = 0; s < 2; s++) begin
			acc[s] = i_vld[s] && !o_busy && i_uop[s].op != NOP;
		end
	end

	// compact survivors toward slot 0, then append in slot order
	always_comb begin
		fill = '0;
		for (int k = 0; k < DEPTH; k++) begin
			nxt[k] = '0;
		end
		for (int k = 0; k < DEPTH; k++) begin
			if (o_entries[k].valid && !i_issued[k]) begin
				nxt[fill[IDX_W-1:0]] = o_entries[k];
				fill = fill + 1'b1;
			end
		end
		for (int s = 0; s < 2; s++) begin
			if (acc[s]) begin
				if (fill < DEPTH) begin
					nxt[fill[IDX_W-1:0]] = '{valid: 1'b1, uop: i_uop[s]};
				end
				fill = fill + 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!rstn) begin
			for (int k = 0; k < DEPTH; k++) begin
				o_entries[k].valid <= 1'b0;
			end
			o_busy <= 1'b0;
		end else begin
			for (int k = 0; k < DEPTH; k++) begin
				o_entries[k] <= nxt[k];
			end
			// low busy guarantees room for a full pair next cycle
			o_busy <= fill > DEPTH - 2;
		end
	end

	a_no_overflow: assert property (@(posedge clk) disable iff (!rstn)
		fill <= DEPTH);

endmodule

// ==== logic/issue_select.sv ====
`timescale 1ns/1ps
`include "core_defs.svh"

module issue_select (
	input  logic                       clk,
	input  logic                       rstn,
	input  pipe_pkg::win_entry_t       i_entries [`CORE_WIN_DEPTH],
	input  logic [`CORE_XLEN-1:0]      i_ds_val [`CORE_WIN_DEPTH],
	input  logic [`CORE_XLEN-1:0]      i_dt_val [`CORE_WIN_DEPTH],
	input  logic [`CORE_N_LANES-1:0]   i_lane_busy,
	input  pipe_pkg::wb_t              i_release [`CORE_N_LANES],
	output logic [`CORE_WIN_DEPTH-1:0] o_issued,
	output pipe_pkg::lane_req_t        o_req [`CORE_N_LANES]
);
	import isa_pkg::*;
	import pipe_pkg::*;

	localparam int DEPTH = `CORE_WIN_DEPTH;
	localparam int LANES = `CORE_N_LANES;
	localparam int IDX_W = $clog2(DEPTH);

	logic [`CORE_NREG-1:0] sb;
	logic [`CORE_NREG-1:0] sb_eff;
	logic [`CORE_NREG-1:0] rel_m;
	logic [`CORE_NREG-1:0] set_m;
	logic [`CORE_NREG-1:0] src_m [DEPTH];
	logic [`CORE_NREG-1:0] dd_m [DEPTH];
	logic [DEPTH-1:0] eligible;
	logic [LANES-1:0] sel_vld;
	logic [IDX_W-1:0] sel_idx [LANES];

	// r0 never enters the scoreboard
	always_comb begin
		for (int k = 0; k < DEPTH; k++) begin
			src_m[k] = '0;
			dd_m[k] = '0;
			if (uses_ds(i_entries[k].uop.op)) begin
				src_m[k][i_entries[k].uop.ds] = 1'b1;
			end
			if (uses_dt(i_entries[k].uop.op)) begin
				src_m[k][i_entries[k].uop.dt] = 1'b1;
			end
			dd_m[k][i_entries[k].uop.dd] = 1'b1;
			src_m[k][0] = 1'b0;
			dd_m[k][0] = 1'b0;
		end
	end

	always_comb begin
		rel_m = '0;
		for (int l = 0; l < LANES; l++) begin
			if (i_release[l].valid) begin
				rel_m[i_release[l].addr] = 1'b1;
			end
		end
	end

	assign sb_eff = sb & ~rel_m;

	// raw, waw and war against every older waiting entry
	always_comb begin
		logic [`CORE_NREG-1:0] older_src;
		logic [`CORE_NREG-1:0] older_dd;
		older_src = '0;
		older_dd = '0;
		for (int k = 0; k < DEPTH; k++) begin
			eligible[k] = i_entries[k].valid
				&& ((src_m[k] | dd_m[k]) & sb_eff) == '0
				&& (src_m[k] & older_dd) == '0
				&& (dd_m[k] & (older_dd | older_src)) == '0;
			if (i_entries[k].valid) begin
				older_src = older_src | src_m[k];
				older_dd = older_dd | dd_m[k];
			end
		end
	end

	// oldest entry gets the lowest free lane
	always_comb begin
		logic [LANES-1:0] lane_free;
		logic taken;
		lane_free = ~i_lane_busy;
		o_issued = '0;
		for (int l = 0; l < LANES; l++) begin
			sel_vld[l] = 1'b0;
			sel_idx[l] = '0;
		end
		for (int k = 0; k < DEPTH; k++) begin
			taken = 1'b0;
			for (int l = 0; l < LANES; l++) begin
				if (eligible[k] && !taken && lane_free[l]) begin
					lane_free[l] = 1'b0;
					sel_vld[l] = 1'b1;
					sel_idx[l] = IDX_W'(k);
					o_issued[k] = 1'b1;
					taken = 1'b1;
				end
			end
		end
	end

	always_comb begin
		set_m = '0;
		for (int k = 0; k < DEPTH; k++) begin
			if (o_issued[k]) begin
				set_m = set_m | dd_m[k];
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!rstn) begin
			sb <= '0;
		end else begin
			sb <= sb_eff | set_m;
		end
	end

	always_ff @(posedge clk) begin
		if (!rstn) begin
			for (int l = 0; l < LANES; l++) begin
				o_req[l].valid <= 1'b0;
			end
		end else begin
			for (int l = 0; l < LANES; l++) begin
				o_req[l].valid <= sel_vld[l];
				o_req[l].op <= i_entries[sel_idx[l]].uop.op;
				o_req[l].dd <= i_entries[sel_idx[l]].uop.dd;
				o_req[l].imm <= i_entries[sel_idx[l]].uop.imm;
				o_req[l].ds_val <= i_ds_val[sel_idx[l]];
				o_req[l].dt_val <= i_dt_val[sel_idx[l]];
			end
		end
	end

	// every lane result frees a register that was marked at issue
	a_sb_release: assert property (@(posedge clk) disable iff (!rstn)
		(rel_m & ~sb) == '0);

endmodule

// ==== logic/exec_lane.sv ====
`timescale 1ns/1ps
`include "core_defs.svh"

module exec_lane (
	input  logic                clk,
	input  logic                rstn,
	input  pipe_pkg::lane_req_t i_req,
	output pipe_pkg::wb_t       o_result,
	output logic                o_lane_busy
);
	import isa_pkg::*;
	import pipe_pkg::*;

	localparam int CH_W = `CORE_XLEN / `CORE_MUL_CYCLES;
	localparam int CNT_W = $clog2(`CORE_MUL_CYCLES + 1);
	localparam int PAD_W = `CORE_XLEN - `CORE_IMM_W;
	localparam int SH_W = $clog2(`CORE_XLEN);

	logic [CNT_W-1:0] mul_cnt;
	logic [`CORE_XLEN-1:0] mul_acc;
	logic [`CORE_XLEN-1:0] mul_a;
	logic [`CORE_XLEN-1:0] mul_b;
	logic [`CORE_XLEN-1:0] mul_sum;
	logic [`CORE_RADDR_W-1:0] mul_dd;
	logic [`CORE_XLEN-1:0] alu_val;
	logic [`CORE_XLEN-1:0] imm_sext;
	logic mul_start;

	assign mul_start = i_req.valid && i_req.op == MUL;
	// free again on the edge that delivers the product
	assign o_lane_busy = mul_start || mul_cnt > 1;

	// one CH_W slice of the multiplier per cycle
	assign mul_sum = mul_acc + mul_a * mul_b[CH_W-1:0];
	assign imm_sext = {{PAD_W{i_req.imm[`CORE_IMM_W-1]}}, i_req.imm};

	always_comb begin
		case (i_req.op)
			ADD:     alu_val = i_req.ds_val + i_req.dt_val;
			SUB:     alu_val = i_req.ds_val - i_req.dt_val;
			AND:     alu_val = i_req.ds_val & i_req.dt_val;
			OR:      alu_val = i_req.ds_val | i_req.dt_val;
			XOR:     alu_val = i_req.ds_val ^ i_req.dt_val;
			SLL:     alu_val = i_req.ds_val << i_req.dt_val[SH_W-1:0];
			SRL:     alu_val = i_req.ds_val >> i_req.dt_val[SH_W-1:0];
			ADDI:    alu_val = i_req.ds_val + imm_sext;
			LUI:     alu_val = {i_req.imm, {PAD_W{1'b0}}};
			default: alu_val = '0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rstn) begin
			mul_cnt <= '0;
			o_result.valid <= 1'b0;
		end else begin
			o_result.valid <= 1'b0;
			if (mul_cnt != 0) begin
				mul_acc <= mul_sum;
				mul_a <= mul_a << CH_W;
				mul_b <= mul_b >> CH_W;
				mul_cnt <= mul_cnt - 1'b1;
				if (mul_cnt == 1) begin
					o_result <= '{valid: mul_dd != '0, addr: mul_dd, data: mul_sum};
				end
			end
			if (mul_start) begin
				// low slice taken right away
				mul_acc <= i_req.ds_val * i_req.dt_val[CH_W-1:0];
				mul_a <= i_req.ds_val << CH_W;
				mul_b <= i_req.dt_val >> CH_W;
				mul_dd <= i_req.dd;
				mul_cnt <= CNT_W'(`CORE_MUL_CYCLES - 1);
			end else if (i_req.valid) begin
				o_result <= '{valid: i_req.dd != '0, addr: i_req.dd, data: alu_val};
			end
		end
	end

	a_req_idle: assert property (@(posedge clk) disable iff (!rstn)
		i_req.valid |-> mul_cnt < 2);

endmodule

// ==== logic/regfile_wb.sv ====
`timescale 1ns/1ps
`include "core_defs.svh"

module regfile_wb (
	input  logic                     clk,
	input  logic                     rstn,
	input  pipe_pkg::wb_t            i_result [`CORE_N_LANES],
	input  logic [`CORE_RADDR_W-1:0] i_rd_addr [`CORE_WIN_DEPTH][2],
	output logic [`CORE_XLEN-1:0]    o_rd_ds [`CORE_WIN_DEPTH],
	output logic [`CORE_XLEN-1:0]    o_rd_dt [`CORE_WIN_DEPTH],
	output pipe_pkg::wb_t            o_wb [`CORE_N_LANES]
);
	localparam int LANES = `CORE_N_LANES;
	localparam int DEPTH = `CORE_WIN_DEPTH;

	logic [`CORE_XLEN-1:0] rf [`CORE_NREG];
	logic [`CORE_XLEN-1:0] rd_val [DEPTH][2];

	// array, then writeback stage, then lane result wins
	always_comb begin
		for (int k = 0; k < DEPTH; k++) begin
			for (int s = 0; s < 2; s++) begin
				rd_val[k][s] = rf[i_rd_addr[k][s]];
				for (int l = 0; l < LANES; l++) begin
					if (o_wb[l].valid && o_wb[l].addr == i_rd_addr[k][s]) begin
						rd_val[k][s] = o_wb[l].data;
					end
				end
				for (int l = 0; l < LANES; l++) begin
					if (i_result[l].valid && i_result[l].addr == i_rd_addr[k][s]) begin
						rd_val[k][s] = i_result[l].data;
					end
				end
				if (i_rd_addr[k][s] == '0) begin
					rd_val[k][s] = '0;
				end
			end
			o_rd_ds[k] = rd_val[k][0];
			o_rd_dt[k] = rd_val[k][1];
		end
	end

	// lanes never mark r0 valid
	always_ff @(posedge clk) begin
		for (int l = 0; l < LANES; l++) begin
			if (i_result[l].valid) begin
				rf[i_result[l].addr] <= i_result[l].data;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!rstn) begin
			for (int l = 0; l < LANES; l++) begin
				o_wb[l].valid <= 1'b0;
			end
		end else begin
			for (int l = 0; l < LANES; l++) begin
				o_wb[l] <= i_result[l];
			end
		end
	end

	for (genvar a = 0; a < LANES; a++) begin : g_wr_a
		for (genvar b = a + 1; b < LANES; b++) begin : g_wr_b
			a_one_writer: assert property (@(posedge clk) disable iff (!rstn)
				!(i_result[a].valid && i_result[b].valid
					&& i_result[a].addr == i_result[b].addr));
		end
	end

endmodule

// ==== logic/ooo_core.sv ====
`timescale 1ns/1ps
`include "core_defs.svh"

module ooo_core (
	input  logic          clk,
	input  logic          rstn,
	input  isa_pkg::uop_t i_uop [2],
	input  logic [1:0]    i_vld,
	output logic          o_busy,
	output pipe_pkg::wb_t o_wb [`CORE_N_LANES]
);
	import pipe_pkg::*;

	win_entry_t entries [`CORE_WIN_DEPTH];
	logic [`CORE_WIN_DEPTH-1:0] issued;
	logic [`CORE_XLEN-1:0] ds_val [`CORE_WIN_DEPTH];
	logic [`CORE_XLEN-1:0] dt_val [`CORE_WIN_DEPTH];
	logic [`CORE_RADDR_W-1:0] rd_addr [`CORE_WIN_DEPTH][2];
	lane_req_t req [`CORE_N_LANES];
	wb_t result [`CORE_N_LANES];
	logic [`CORE_N_LANES-1:0] lane_busy;

	for (genvar k = 0; k < `CORE_WIN_DEPTH; k++) begin : g_rd
		assign rd_addr[k][0] = entries[k].uop.ds;
		assign rd_addr[k][1] = entries[k].uop.dt;
	end

	issue_window u_window (
		.clk(clk),
		.rstn(rstn),
		.i_uop(i_uop),
		.i_vld(i_vld),
		.i_issued(issued),
		.o_entries(entries),
		.o_busy(o_busy)
	);

	// lane results release the scoreboard in their own cycle
	issue_select u_select (
		.clk(clk),
		.rstn(rstn),
		.i_entries(entries),
		.i_ds_val(ds_val),
		.i_dt_val(dt_val),
		.i_lane_busy(lane_busy),
		.i_release(result),
		.o_issued(issued),
		.o_req(req)
	);

	for (genvar l = 0; l < `CORE_N_LANES; l++) begin : g_lane
		exec_lane u_lane (
			.clk(clk),
			.rstn(rstn),
			.i_req(req[l]),
			.o_result(result[l]),
			.o_lane_busy(lane_busy[l])
		);
	end

	regfile_wb u_regfile_wb (
		.clk(clk),
		.rstn(rstn),
		.i_result(result),
		.i_rd_addr(rd_addr),
		.o_rd_ds(ds_val),
		.o_rd_dt(dt_val),
		.o_wb(o_wb)
	);

endmodule

// ==== verif/tb_clock.sv ====
`timescale 1ns/1ps

module tb_clock #(
	parameter int RESET_CYCLES = 4
) (
	output logic clk,
	output logic rstn
);
	// 4 ns period
	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	initial begin
		rstn = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		rstn <= 1'b1;
	end

endmodule

// ==== verif/core_checker.sv ====
`timescale 1ns/1ps
`include "core_defs.svh"

module core_checker (
	input  logic          clk,
	input  logic          rstn,
	input  isa_pkg::uop_t i_uop [2],
	input  logic [1:0]    i_vld,
	input  logic          i_busy,
	input  pipe_pkg::wb_t i_wb [`CORE_N_LANES],
	output int            o_mismatch_cnt,
	output int            o_error_cnt,
	output int            o_pending
);
	import isa_pkg::*;
	import pipe_pkg::*;

	localparam int PAD_W = `CORE_XLEN - `CORE_IMM_W;

	// one outstanding register write in program order
	typedef struct packed {
		logic [`CORE_RADDR_W-1:0] dd;
		logic [`CORE_XLEN-1:0]    val;
		int                       cyc;
		int                       min_lat;
		logic                     timed;
	} expect_t;

	logic [`CORE_XLEN-1:0] model_rf [`CORE_NREG];
	expect_t pend [$];
	int cyc = 0;
	int mismatch_cnt = 0;
	int error_cnt = 0;
	int pend_cnt = 0;
	logic rst_q1 = 1'b1;
	logic rst_q2 = 1'b1;

	assign o_mismatch_cnt = mismatch_cnt;
	assign o_error_cnt = error_cnt;
	assign o_pending = pend_cnt;

	function automatic logic [`CORE_XLEN-1:0] reference_result(input uop_t u,
		input logic [`CORE_XLEN-1:0] a, input logic [`CORE_XLEN-1:0] b);
		case (u.op)
			ADD:     return a + b;
			SUB:     return a - b;
			AND:     return a & b;
			OR:      return a | b;
			XOR:     return a ^ b;
			SLL:     return a << b[4:0];
			SRL:     return a >> b[4:0];
			ADDI:    return a + {{PAD_W{u.imm[`CORE_IMM_W-1]}}, u.imm};
			LUI:     return {u.imm, {PAD_W{1'b0}}};
			MUL:     return a * b;
			default: return '0;
		endcase
	endfunction

	task automatic accept_op(input uop_t u);
		expect_t e;
		int same;
		if (u.op == NOP || u.dd == '0) begin
			return;
		end
		same = 0;
		foreach (pend[i]) begin
			if (pend[i].dd == u.dd) begin
				same++;
			end
		end
		e.dd = u.dd;
		e.val = reference_result(u, model_rf[u.ds], model_rf[u.dt]);
		e.cyc = cyc;
		e.min_lat = (u.op == MUL) ? `CORE_MUL_CYCLES + 2 : 3;
		// latency only meaningful with no older write to the same register
		e.timed = (same == 0);
		model_rf[u.dd] = e.val;
		pend.push_back(e);
	endtask

	task automatic check_writeback(input wb_t w);
		int idx;
		int lat;
		idx = -1;
		if (w.addr == '0) begin
			$display("error at %0t: writeback addresses r0", $time);
			error_cnt++;
			return;
		end
		foreach (pend[i]) begin
			if (idx < 0 && pend[i].dd == w.addr) begin
				idx = i;
			end
		end
		if (idx < 0) begin
			$display("error at %0t: writeback to r%0d with no operation pending", $time, w.addr);
			error_cnt++;
			return;
		end
		if (pend[idx].val !== w.data) begin
			$display("mismatch at %0t: r%0d got %08h expected %08h",
				$time, w.addr, w.data, pend[idx].val);
			mismatch_cnt++;
		end
		// value seen here was registered on the previous edge
		lat = cyc - 1 - pend[idx].cyc;
		if (pend[idx].timed && lat < pend[idx].min_lat) begin
			$display("error at %0t: r%0d written back %0d cycles after acceptance, minimum is %0d",
				$time, w.addr, lat, pend[idx].min_lat);
			error_cnt++;
		end
		pend.delete(idx);
	endtask

	task automatic check_idle();
		if (i_busy !== 1'b0) begin
			$display("error at %0t: o_busy not low around reset", $time);
			error_cnt++;
		end
		for (int l = 0; l < `CORE_N_LANES; l++) begin
			if (i_wb[l].valid !== 1'b0) begin
				$display("error at %0t: writeback %0d valid around reset", $time, l);
				error_cnt++;
			end
		end
	endtask

	always @(posedge clk) begin
		cyc = cyc + 1;
		if (!rst_q1 || !rst_q2) begin
			check_idle();
		end else begin
			for (int l = 0; l < `CORE_N_LANES; l++) begin
				if (i_wb[l].valid === 1'b1) begin
					check_writeback(i_wb[l]);
				end
			end
		end
		if (!rstn) begin
			for (int r = 0; r < `CORE_NREG; r++) begin
				model_rf[r] = '0;
			end
			pend.delete();
		end else if (!i_busy) begin
			// slot 0 is older
			for (int s = 0; s < 2; s++) begin
				if (i_vld[s]) begin
					accept_op(i_uop[s]);
				end
			end
		end
		pend_cnt = pend.size();
		rst_q2 = rst_q1;
		rst_q1 = rstn;
	end

endmodule

// ==== verif/tb_core.sv ====
`timescale 1ns/1ps
`include "core_defs.svh"

module tb_core;
	import isa_pkg::*;
	import pipe_pkg::*;

	localparam int STIM_CYCLES = 2000;
	localparam int WAIT_LIMIT = 2000;

	logic clk;
	logic rstn;
	uop_t uop [2];
	logic [1:0] vld;
	logic busy;
	wb_t wb [`CORE_N_LANES];
	int mismatch_cnt;
	int error_cnt;
	int pending_cnt;
	int timeout_cnt;
	logic [31:0] lfsr;

	tb_clock u_clock (
		.clk(clk),
		.rstn(rstn)
	);

	ooo_core i_ooo_core (
		.clk(clk),
		.rstn(rstn),
		.i_uop(uop),
		.i_vld(vld),
		.o_busy(busy),
		.o_wb(wb)
	);

	core_checker u_checker (
		.clk(clk),
		.rstn(rstn),
		.i_uop(uop),
		.i_vld(vld),
		.i_busy(busy),
		.i_wb(wb),
		.o_mismatch_cnt(mismatch_cnt),
		.o_error_cnt(error_cnt),
		.o_pending(pending_cnt)
	);

	// taps 32 22 2 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic take_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[30:0], lfsr[31]};
			lfsr = lfsr_next(lfsr);
		end
	endtask

	task automatic random_uop(output uop_t u);
		logic [31:0] v;
		v = 32'd11;
		// redraw codes outside the 11 defined operations
		while (v >= 32'd11) begin
			take_bits(4, v);
		end
		u.op = op_e'(v[3:0]);
		take_bits(3, v);
		u.ds = `CORE_RADDR_W'(v[2:0]);
		take_bits(3, v);
		u.dt = `CORE_RADDR_W'(v[2:0]);
		take_bits(3, v);
		u.dd = `CORE_RADDR_W'(v[2:0]);
		take_bits(`CORE_IMM_W, v);
		u.imm = v[`CORE_IMM_W-1:0];
	endtask

	initial begin
		logic [31:0] v;
		uop_t u;
		int n;
		int waited;
		lfsr = 32'h3d17ca7a;
		vld = 2'b00;
		uop[0] = '0;
		uop[1] = '0;
		timeout_cnt = 0;
		waited = 0;
		while (!rstn && waited < 100) begin
			@(posedge clk);
			waited++;
		end
		if (!rstn) begin
			$display("error at %0t: reset still asserted after %0d cycles", $time, waited);
			timeout_cnt++;
		end

		// give r1..r7 known values before random traffic
		n = 1;
		waited = 0;
		while (n < 8 && waited < WAIT_LIMIT) begin
			@(posedge clk);
			waited++;
			if (!busy) begin
				take_bits(`CORE_IMM_W, v);
				u.op = ADDI;
				u.ds = '0;
				u.dt = '0;
				u.dd = `CORE_RADDR_W'(n);
				u.imm = v[`CORE_IMM_W-1:0];
				uop[0] <= u;
				vld <= 2'b01;
				n++;
			end
		end
		if (n < 8) begin
			$display("error at %0t: register setup stalled by o_busy", $time);
			timeout_cnt++;
		end

		for (int c = 0; c < STIM_CYCLES; c++) begin
			@(posedge clk);
			if (!busy) begin
				random_uop(u);
				uop[0] <= u;
				random_uop(u);
				uop[1] <= u;
				take_bits(2, v);
				vld[0] <= v[1:0] != 2'b00;
				take_bits(2, v);
				vld[1] <= v[1:0] != 2'b00;
			end
		end

		// last pair must be taken before the inputs go idle
		waited = 0;
		@(posedge clk);
		while (busy && waited < WAIT_LIMIT) begin
			@(posedge clk);
			waited++;
		end
		if (busy) begin
			$display("error at %0t: o_busy stuck high at end of stimulus", $time);
			timeout_cnt++;
		end
		vld <= 2'b00;

		waited = 0;
		@(negedge clk);
		while (pending_cnt != 0 && waited < WAIT_LIMIT) begin
			@(negedge clk);
			waited++;
		end
		if (pending_cnt != 0) begin
			$display("error at %0t: %0d writebacks still missing after drain timeout",
				$time, pending_cnt);
			timeout_cnt++;
		end
		// catch stray writebacks
		for (int c = 0; c < 20; c++) begin
			@(negedge clk);
		end

		$display("errors: %0d mismatch, %0d other, %0d timeout",
			mismatch_cnt, error_cnt, timeout_cnt);
		if (mismatch_cnt == 0 && error_cnt == 0 && timeout_cnt == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

endmodule

// ==== all.f ====
+incdir+include
logic/isa_pkg.sv
logic/pipe_pkg.sv
logic/issue_window.sv
logic/issue_select.sv
logic/exec_lane.sv
logic/regfile_wb.sv
logic/ooo_core.sv
verif/tb_clock.sv
verif/core_checker.sv
verif/tb_core.sv

// ==== run.sh ====
#!/bin/sh
# compile and run the core testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -f all.f --top-module tb_core -Mdir obj_dir -o sim_core
status=$?
if [ $status -ne 0 ]; then
	echo "verilator build failed with status $status"
	exit 1
fi

./obj_dir/sim_core > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "^PASS: all tests$" "$LOG"; then
	exit 0
fi
exit 1
